/* logic/cpuPkg.sv */
package cpuPkg;

  localparam int xlen = 32;
  localparam int regIndexWidth = 5;
  localparam int memWords = 64;
  localparam int memIndexWidth = $clog2(memWords);

  // data addresses at or above mmioBase are peripherals
  localparam logic [xlen-1:0] mmioBase = 32'h0000_0100;
  localparam logic [xlen-1:0] storePortAddress = 32'h0000_0100;
  localparam logic [xlen-1:0] ledAddress = 32'h0000_0104;

  localparam logic [6:0] opReg = 7'b0110011;
  localparam logic [6:0] opImm = 7'b0010011;
  localparam logic [6:0] opLoad = 7'b0000011;
  localparam logic [6:0] opStore = 7'b0100011;
  localparam logic [6:0] opBranch = 7'b1100011;

  typedef enum logic [2:0] {
    aluAdd,
    aluSub,
    aluAnd,
    aluOr,
    aluXor,
    aluSlt
  } aluOpT;

  typedef enum logic [1:0] {
    forwardNone,
    forwardFromMemory,
    forwardFromWriteback
  } forwardSelT;

  typedef struct packed {
    logic [xlen-1:0] pc;
    logic [xlen-1:0] instruction;
  } ifIdT;

  // all flags clear means a bubble
  typedef struct packed {
    logic [xlen-1:0] pc;
    logic [xlen-1:0] sourceValueA;
    logic [xlen-1:0] sourceValueB;
    logic [regIndexWidth-1:0] sourceIndexA;
    logic [regIndexWidth-1:0] sourceIndexB;
    logic [regIndexWidth-1:0] destIndex;
    logic [xlen-1:0] immediate;
    aluOpT aluOp;
    logic useImmediate;
    logic memRead;
    logic memWrite;
    logic regWrite;
    logic isBranch;
    logic branchOnNotEqual;
  } idExT;

  typedef struct packed {
    logic [xlen-1:0] aluResult;
    logic [xlen-1:0] storeData;
    logic [regIndexWidth-1:0] destIndex;
    logic memRead;
    logic memWrite;
    logic regWrite;
  } exMemT;

  // load data is already merged into result
  typedef struct packed {
    logic [xlen-1:0] result;
    logic [regIndexWidth-1:0] destIndex;
    logic regWrite;
  } memWbT;

endpackage

/* logic/pipeBarrier.sv */
`timescale 1ns/1ps

module pipeBarrier #(
  parameter type payloadT = logic
) (
  input  logic    clk,
  input  logic    reset,
  input  logic    hold,
  input  logic    flush,
  input  payloadT dataIn,
  output payloadT dataOut
);

  // hold wins over flush so a frozen stage keeps its instruction
  always_ff @(posedge clk) begin
    if (reset) begin
      dataOut <= '0;
    end else if (hold) begin
      dataOut <= dataOut;
    end else if (flush) begin
      dataOut <= '0;
    end else begin
      dataOut <= dataIn;
    end
  end

endmodule

/* logic/instructionMemory.sv */
`timescale 1ns/1ps

module instructionMemory import cpuPkg::*; (
  input  logic                     clk,
  input  logic                     progWrite,
  input  logic [memIndexWidth-1:0] progAddress,
  input  logic [xlen-1:0]          progData,
  input  logic [xlen-1:0]          fetchAddress,
  output logic [xlen-1:0]          instruction
);

  logic [xlen-1:0] words [memWords];
  logic [memIndexWidth-1:0] fetchIndex;

  // byte address to word index
  assign fetchIndex = fetchAddress[memIndexWidth+1:2];

  always_ff @(posedge clk) begin
    if (progWrite) begin
      words[progAddress] <= progData;
    end
  end

  assign instruction = words[fetchIndex];

endmodule

/* logic/decoder.sv */
`timescale 1ns/1ps

module decoder import cpuPkg::*; (
  input  logic [xlen-1:0] instruction,
  output aluOpT           aluOp,
  output logic            useImmediate,
  output logic            memRead,
  output logic            memWrite,
  output logic            regWrite,
  output logic            isBranch,
  output logic            branchOnNotEqual,
  output logic [xlen-1:0] immediate
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic [xlen-1:0] immI;
  logic [xlen-1:0] immS;
  logic [xlen-1:0] immB;

  assign opcode = instruction[6:0];
  assign funct3 = instruction[14:12];
  assign funct7 = instruction[31:25];

  assign immI = {{20{instruction[31]}}, instruction[31:20]};
  assign immS = {{20{instruction[31]}}, instruction[31:25], instruction[11:7]};
  assign immB = {{19{instruction[31]}}, instruction[31], instruction[7],
                 instruction[30:25], instruction[11:8], 1'b0};

  always_comb begin
    aluOp = aluAdd;
    useImmediate = 1'b0;
    memRead = 1'b0;
    memWrite = 1'b0;
    regWrite = 1'b0;
    isBranch = 1'b0;
    branchOnNotEqual = 1'b0;
    immediate = '0;
    case (opcode)
      opReg: begin
        regWrite = 1'b1;
        case ({funct7, funct3})
          {7'b0000000, 3'b000}: aluOp = aluAdd;
          {7'b0100000, 3'b000}: aluOp = aluSub;
          {7'b0000000, 3'b111}: aluOp = aluAnd;
          {7'b0000000, 3'b110}: aluOp = aluOr;
          {7'b0000000, 3'b100}: aluOp = aluXor;
          {7'b0000000, 3'b010}: aluOp = aluSlt;
          default: regWrite = 1'b0;
        endcase
      end
      opImm: begin
        // only addi
        if (funct3 == 3'b000) begin
          regWrite = 1'b1;
          useImmediate = 1'b1;
          immediate = immI;
        end
      end
      opLoad: begin
        if (funct3 == 3'b010) begin
          regWrite = 1'b1;
          memRead = 1'b1;
          useImmediate = 1'b1;
          immediate = immI;
        end
      end
      opStore: begin
        if (funct3 == 3'b010) begin
          memWrite = 1'b1;
          useImmediate = 1'b1;
          immediate = immS;
        end
      end
      opBranch: begin
        // beq is 000, bne is 001
        if (funct3[2:1] == 2'b00) begin
          isBranch = 1'b1;
          branchOnNotEqual = funct3[0];
          aluOp = aluSub;
          immediate = immB;
        end
      end
      default: ;
    endcase
  end

endmodule

/* logic/registerFile.sv */
`timescale 1ns/1ps

module registerFile import cpuPkg::*; (
  input  logic                     clk,
  input  logic                     reset,
  input  logic [regIndexWidth-1:0] readIndexA,
  input  logic [regIndexWidth-1:0] readIndexB,
  input  logic [regIndexWidth-1:0] writeIndex,
  input  logic [xlen-1:0]          writeData,
  input  logic                     writeEnable,
  output logic [xlen-1:0]          readDataA,
  output logic [xlen-1:0]          readDataB
);

  logic [xlen-1:0] registers [2**regIndexWidth];
  logic writeLive;

  // x0 never takes a write
  assign writeLive = writeEnable && (writeIndex != '0);

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < 2**regIndexWidth; i++) begin
        registers[i] <= '0;
      end
    end else if (writeLive) begin
      registers[writeIndex] <= writeData;
    end
  end

  // same-cycle write shows through to decode
  assign readDataA = (writeLive && writeIndex == readIndexA) ? writeData : registers[readIndexA];
  assign readDataB = (writeLive && writeIndex == readIndexB) ? writeData : registers[readIndexB];

endmodule

/* logic/alu.sv */
`timescale 1ns/1ps

module alu import cpuPkg::*; (
  input  aluOpT           aluOp,
  input  logic [xlen-1:0] operandA,
  input  logic [xlen-1:0] operandB,
  output logic [xlen-1:0] result,
  output logic            equal
);

  always_comb begin
    case (aluOp)
      aluAdd: result = operandA + operandB;
      aluSub: result = operandA - operandB;
      aluAnd: result = operandA & operandB;
      aluOr:  result = operandA | operandB;
      aluXor: result = operandA ^ operandB;
      aluSlt: begin
        result = '0;
        result[0] = $signed(operandA) < $signed(operandB);
      end
      default: result = '0;
    endcase
  end

  // branch decision uses this, not the result
  assign equal = operandA == operandB;

endmodule

/* logic/hazardUnit.sv */
`timescale 1ns/1ps

module hazardUnit import cpuPkg::*; (
  input  logic [regIndexWidth-1:0] decodeSourceA,
  input  logic [regIndexWidth-1:0] decodeSourceB,
  input  logic [regIndexWidth-1:0] executeSourceA,
  input  logic [regIndexWidth-1:0] executeSourceB,
  input  logic [regIndexWidth-1:0] executeDest,
  input  logic                     executeMemRead,
  input  logic [regIndexWidth-1:0] memoryDest,
  input  logic                     memoryRegWrite,
  input  logic [regIndexWidth-1:0] writebackDest,
  input  logic                     writebackRegWrite,
  input  logic                     memoryBlocked,
  output logic                     stall,
  output logic                     freeze,
  output forwardSelT               forwardA,
  output forwardSelT               forwardB
);

  function automatic forwardSelT selectSource(logic [regIndexWidth-1:0] source);
    forwardSelT sel;
    sel = forwardNone;
    if (source != '0) begin
      // memory stage holds the younger value
      if (memoryRegWrite && memoryDest == source) begin
        sel = forwardFromMemory;
      end else if (writebackRegWrite && writebackDest == source) begin
        sel = forwardFromWriteback;
      end
    end
    return sel;
  endfunction

  assign stall = executeMemRead && (executeDest != '0) &&
                 (executeDest == decodeSourceA || executeDest == decodeSourceB);
  assign freeze = memoryBlocked;

  assign forwardA = selectSource(executeSourceA);
  assign forwardB = selectSource(executeSourceB);

endmodule

/* logic/memoryManagementUnit.sv */
`timescale 1ns/1ps

module memoryManagementUnit import cpuPkg::*; (
  input  logic            clk,
  input  logic            reset,
  input  logic [xlen-1:0] address,
  input  logic [xlen-1:0] writeData,
  input  logic            memRead,
  input  logic            memWrite,
  input  logic            storeReady,
  output logic [xlen-1:0] readData,
  output logic            blocked,
  output logic            storeValid,
  output logic [xlen-1:0] storeAddress,
  output logic [xlen-1:0] storeData,
  output logic [7:0]      led
);

  logic [xlen-1:0] dataRam [memWords];
  logic [memIndexWidth-1:0] ramIndex;
  logic isRam;
  logic isLed;
  logic isStorePort;

  assign isRam = address < mmioBase;
  assign isLed = address == ledAddress;
  assign isStorePort = address == storePortAddress;
  assign ramIndex = address[memIndexWidth+1:2];

  always_ff @(posedge clk) begin
    if (memWrite && isRam) begin
      dataRam[ramIndex] <= writeData;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      led <= '0;
    end else if (memWrite && isLed) begin
      led <= writeData[7:0];
    end
  end

  // store port and unmapped addresses read as zero
  always_comb begin
    readData = '0;
    if (memRead) begin
      if (isRam) begin
        readData = dataRam[ramIndex];
      end else if (isLed) begin
        readData = {{(xlen-8){1'b0}}, led};
      end
    end
  end

  // held stable by the freeze until the transfer cycle
  assign storeValid = memWrite && isStorePort;
  assign storeAddress = address;
  assign storeData = writeData;
  assign blocked = storeValid && !storeReady;

endmodule

/* logic/cpu.sv */
`timescale 1ns/1ps

module cpu import cpuPkg::*; (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     progWrite,
  input  logic [memIndexWidth-1:0] progAddress,
  input  logic [xlen-1:0]          progData,
  input  logic                     storeReady,
  output logic                     storeValid,
  output logic [xlen-1:0]          storeAddress,
  output logic [xlen-1:0]          storeData,
  output logic [7:0]               led
);

  logic [xlen-1:0] pc;
  logic [xlen-1:0] fetchedInstruction;
  logic stall;
  logic freeze;
  logic branchTaken;
  logic [xlen-1:0] branchTarget;
  forwardSelT forwardA;
  forwardSelT forwardB;

  ifIdT ifIdIn, ifIdOut;
  idExT idExIn, idExOut;
  exMemT exMemIn, exMemOut;
  memWbT memWbIn, memWbOut;

  aluOpT decodeAluOp;
  logic decodeUseImmediate;
  logic decodeMemRead;
  logic decodeMemWrite;
  logic decodeRegWrite;
  logic decodeIsBranch;
  logic decodeBranchOnNotEqual;
  logic [xlen-1:0] decodeImmediate;
  logic [xlen-1:0] decodeValueA;
  logic [xlen-1:0] decodeValueB;

  logic [xlen-1:0] operandA;
  logic [xlen-1:0] forwardedB;
  logic [xlen-1:0] operandB;
  logic [xlen-1:0] aluResult;
  logic aluEqual;

  logic [xlen-1:0] loadData;
  logic memoryBlocked;

  function automatic logic [xlen-1:0] pickOperand(forwardSelT sel, logic [xlen-1:0] regValue,
                                                  logic [xlen-1:0] memoryValue,
                                                  logic [xlen-1:0] writebackValue);
    logic [xlen-1:0] value;
    case (sel)
      forwardFromMemory: value = memoryValue;
      forwardFromWriteback: value = writebackValue;
      default: value = regValue;
    endcase
    return value;
  endfunction

  // fetch
  always_ff @(posedge clk) begin
    if (reset) begin
      pc <= '0;
    end else if (!freeze) begin
      if (branchTaken) begin
        pc <= branchTarget;
      end else if (!stall) begin
        pc <= pc + 4;
      end
    end
  end

  instructionMemory instructionMemory(
    .clk(clk),
    .progWrite(progWrite),
    .progAddress(progAddress),
    .progData(progData),
    .fetchAddress(pc),
    .instruction(fetchedInstruction)
  );

  assign ifIdIn = '{pc: pc, instruction: fetchedInstruction};

  pipeBarrier #(.payloadT(ifIdT)) ifIdBarrier(
    .clk(clk),
    .reset(reset),
    .hold(stall | freeze),
    .flush(branchTaken),
    .dataIn(ifIdIn),
    .dataOut(ifIdOut)
  );

  // decode
  decoder decoder(
    .instruction(ifIdOut.instruction),
    .aluOp(decodeAluOp),
    .useImmediate(decodeUseImmediate),
    .memRead(decodeMemRead),
    .memWrite(decodeMemWrite),
    .regWrite(decodeRegWrite),
    .isBranch(decodeIsBranch),
    .branchOnNotEqual(decodeBranchOnNotEqual),
    .immediate(decodeImmediate)
  );

  registerFile registerFile(
    .clk(clk),
    .reset(reset),
    .readIndexA(ifIdOut.instruction[19:15]),
    .readIndexB(ifIdOut.instruction[24:20]),
    .writeIndex(memWbOut.destIndex),
    .writeData(memWbOut.result),
    .writeEnable(memWbOut.regWrite),
    .readDataA(decodeValueA),
    .readDataB(decodeValueB)
  );

  always_comb begin
    idExIn.pc = ifIdOut.pc;
    idExIn.sourceValueA = decodeValueA;
    idExIn.sourceValueB = decodeValueB;
    idExIn.sourceIndexA = ifIdOut.instruction[19:15];
    idExIn.sourceIndexB = ifIdOut.instruction[24:20];
    idExIn.destIndex = ifIdOut.instruction[11:7];
    idExIn.immediate = decodeImmediate;
    idExIn.aluOp = decodeAluOp;
    idExIn.useImmediate = decodeUseImmediate;
    idExIn.memRead = decodeMemRead;
    idExIn.memWrite = decodeMemWrite;
    idExIn.regWrite = decodeRegWrite;
    idExIn.isBranch = decodeIsBranch;
    idExIn.branchOnNotEqual = decodeBranchOnNotEqual;
  end

  hazardUnit hazardUnit(
    .decodeSourceA(ifIdOut.instruction[19:15]),
    .decodeSourceB(ifIdOut.instruction[24:20]),
    .executeSourceA(idExOut.sourceIndexA),
    .executeSourceB(idExOut.sourceIndexB),
    .executeDest(idExOut.destIndex),
    .executeMemRead(idExOut.memRead),
    .memoryDest(exMemOut.destIndex),
    .memoryRegWrite(exMemOut.regWrite),
    .writebackDest(memWbOut.destIndex),
    .writebackRegWrite(memWbOut.regWrite),
    .memoryBlocked(memoryBlocked),
    .stall(stall),
    .freeze(freeze),
    .forwardA(forwardA),
    .forwardB(forwardB)
  );

  // a load-use stall leaves a bubble behind the load
  pipeBarrier #(.payloadT(idExT)) idExBarrier(
    .clk(clk),
    .reset(reset),
    .hold(freeze),
    .flush(stall | branchTaken),
    .dataIn(idExIn),
    .dataOut(idExOut)
  );

  // execute
  assign operandA = pickOperand(forwardA, idExOut.sourceValueA, exMemOut.aluResult,
                                memWbOut.result);
  assign forwardedB = pickOperand(forwardB, idExOut.sourceValueB, exMemOut.aluResult,
                                  memWbOut.result);
  assign operandB = idExOut.useImmediate ? idExOut.immediate : forwardedB;

  alu alu(
    .aluOp(idExOut.aluOp),
    .operandA(operandA),
    .operandB(operandB),
    .result(aluResult),
    .equal(aluEqual)
  );

  assign branchTarget = idExOut.pc + idExOut.immediate;
  assign branchTaken = idExOut.isBranch && (aluEqual != idExOut.branchOnNotEqual);

  assign exMemIn = '{aluResult: aluResult, storeData: forwardedB, destIndex: idExOut.destIndex,
                     memRead: idExOut.memRead, memWrite: idExOut.memWrite,
                     regWrite: idExOut.regWrite};

  pipeBarrier #(.payloadT(exMemT)) exMemBarrier(
    .clk(clk),
    .reset(reset),
    .hold(freeze),
    .flush(1'b0),
    .dataIn(exMemIn),
    .dataOut(exMemOut)
  );

  // memory
  memoryManagementUnit memoryManagementUnit(
    .clk(clk),
    .reset(reset),
    .address(exMemOut.aluResult),
    .writeData(exMemOut.storeData),
    .memRead(exMemOut.memRead),
    .memWrite(exMemOut.memWrite),
    .storeReady(storeReady),
    .readData(loadData),
    .blocked(memoryBlocked),
    .storeValid(storeValid),
    .storeAddress(storeAddress),
    .storeData(storeData),
    .led(led)
  );

  // writeback value chosen before the last barrier
  assign memWbIn = '{result: exMemOut.memRead ? loadData : exMemOut.aluResult,
                     destIndex: exMemOut.destIndex, regWrite: exMemOut.regWrite};

  pipeBarrier #(.payloadT(memWbT)) memWbBarrier(
    .clk(clk),
    .reset(reset),
    .hold(freeze),
    .flush(1'b0),
    .dataIn(memWbIn),
    .dataOut(memWbOut)
  );

endmodule

/* tb/cpu_checker.sv */
`timescale 1ns/1ps

module cpu_checker import cpuPkg::*; (
  input logic            clk,
  input logic            reset,
  input logic            storeValid,
  input logic            storeReady,
  input logic [xlen-1:0] storeAddress,
  input logic [xlen-1:0] storeData,
  input logic [7:0]      led
);

  int violations = 0;

  // a waiting store keeps valid, address and data until it is taken
  holdUntilReady: assert property (@(posedge clk) disable iff (reset)
    storeValid && !storeReady |=> storeValid && $stable(storeAddress) && $stable(storeData))
    else begin
      violations++;
      $error("store port dropped or changed a waiting transfer");
    end

  // one reset edge is enough to clear the port and the LEDs
  resetClearsOutputs: assert property (@(posedge clk)
    $past(reset) |-> !storeValid && led == 8'h00)
    else begin
      violations++;
      $error("storeValid or led not cleared by reset");
    end

  validKnown: assert property (@(posedge clk) disable iff (reset) !$isunknown(storeValid))
    else begin
      violations++;
      $error("storeValid is unknown outside reset");
    end

endmodule

bind cpu cpu_checker storeChecks(
  .clk(clk),
  .reset(reset),
  .storeValid(storeValid),
  .storeReady(storeReady),
  .storeAddress(storeAddress),
  .storeData(storeData),
  .led(led)
);

/* tb/cpuTb.sv */
`timescale 1ns/1ps

module cpuTb import cpuPkg::*; ();

  logic clk;
  logic reset;
  logic progWrite;
  logic [memIndexWidth-1:0] progAddress;
  logic [xlen-1:0] progData;
  logic storeReady;
  logic storeValid;
  logic [xlen-1:0] storeAddress;
  logic [xlen-1:0] storeData;
  logic [7:0] led;

  int seed = 54667;
  logic [xlen-1:0] programWords [memWords];
  logic [xlen-1:0] expectedAddress [$];
  logic [xlen-1:0] expectedData [$];
  logic [7:0] expectedLed;
  int transfers;
  int expectedTransfers;

  cpu u_cpu(
    .clk(clk),
    .reset(reset),
    .progWrite(progWrite),
    .progAddress(progAddress),
    .progData(progData),
    .storeReady(storeReady),
    .storeValid(storeValid),
    .storeAddress(storeAddress),
    .storeData(storeData),
    .led(led)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #50 clk = ~clk;
    end
  end

  task automatic failRun(input string what);
    $display("%s", what);
    $display("FAIL: see errors above");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic checkStore(input logic [xlen-1:0] gotAddress, input logic [xlen-1:0] gotData,
                            input logic [xlen-1:0] wantAddress, input logic [xlen-1:0] wantData);
    if (gotAddress !== wantAddress) begin
      failRun($sformatf("MISMATCH storeAddress expected %h got %h", wantAddress, gotAddress));
    end
    if (gotData !== wantData) begin
      failRun($sformatf("MISMATCH storeData expected %h got %h", wantData, gotData));
    end
  endtask

  task automatic checkLed(input logic [7:0] got, input logic [7:0] want);
    if (got !== want) begin
      failRun($sformatf("MISMATCH led expected %h got %h", want, got));
    end
  endtask

  task automatic checkValid(input logic got, input logic want);
    if (got !== want) begin
      failRun($sformatf("MISMATCH storeValid expected %h got %h", want, got));
    end
  endtask

  function automatic int randomBelow(input int range);
    return int'($unsigned($random(seed)) % range);
  endfunction

  function automatic logic [31:0] encodeReg(input logic [6:0] funct7, input logic [2:0] funct3,
                                            input logic [4:0] rd, input logic [4:0] rs1,
                                            input logic [4:0] rs2);
    return {funct7, rs2, rs1, funct3, rd, opReg};
  endfunction

  function automatic logic [31:0] encodeImm(input logic [6:0] opcode, input logic [2:0] funct3,
                                            input logic [4:0] rd, input logic [4:0] rs1,
                                            input logic [11:0] imm);
    return {imm, rs1, funct3, rd, opcode};
  endfunction

  // stores always use x0 as the base
  function automatic logic [31:0] encodeStore(input logic [4:0] rs2, input logic [11:0] offset);
    return {offset[11:5], rs2, 5'd0, 3'b010, offset[4:0], opStore};
  endfunction

  function automatic logic [31:0] encodeBranch(input logic notEqual, input logic [4:0] rs1,
                                               input logic [4:0] rs2, input logic [12:0] offset);
    return {offset[12], offset[10:5], rs2, rs1, 2'b00, notEqual, offset[4:1], offset[11],
            opBranch};
  endfunction

  // mostly ram words 0 to 7, sometimes the LED or the store port
  function automatic logic [11:0] dataOffset();
    int choice;
    choice = randomBelow(10);
    if (choice < 6) begin
      return 12'(4 * randomBelow(8));
    end else if (choice < 8) begin
      return 12'h104;
    end
    return 12'h100;
  endfunction

  // words 0-7 clear ram, 8-55 random, 56-62 dump x1-x7, 63 self loop
  task automatic buildProgram();
    int kind;
    int reach;
    logic [4:0] rd;
    logic [4:0] rs1;
    logic [4:0] rs2;
    for (int i = 0; i < 8; i++) begin
      programWords[i] = encodeStore(5'd0, 12'(4 * i));
    end
    for (int i = 8; i < 56; i++) begin
      rd = 5'(1 + randomBelow(7));
      rs1 = 5'(1 + randomBelow(7));
      rs2 = 5'(1 + randomBelow(7));
      // no room for a two-instruction branch in the last slot
      kind = randomBelow((i < 55) ? 11 : 9);
      case (kind)
        0: programWords[i] = encodeReg(7'h00, 3'b000, rd, rs1, rs2);
        1: programWords[i] = encodeReg(7'h20, 3'b000, rd, rs1, rs2);
        2: programWords[i] = encodeReg(7'h00, 3'b111, rd, rs1, rs2);
        3: programWords[i] = encodeReg(7'h00, 3'b110, rd, rs1, rs2);
        4: programWords[i] = encodeReg(7'h00, 3'b100, rd, rs1, rs2);
        5: programWords[i] = encodeReg(7'h00, 3'b010, rd, rs1, rs2);
        6: programWords[i] = encodeImm(opImm, 3'b000, rd, rs1, 12'(randomBelow(4096)));
        7: programWords[i] = encodeImm(opLoad, 3'b010, rd, 5'd0, dataOffset());
        8: programWords[i] = encodeStore(rs2, dataOffset());
        default: begin
          // forward only and never past the register dump
          reach = 2 + randomBelow(5);
          if (i + reach > 56) begin
            reach = 56 - i;
          end
          programWords[i] = encodeBranch(kind == 10, rs1, rs2, 13'(4 * reach));
        end
      endcase
    end
    for (int i = 56; i < 63; i++) begin
      programWords[i] = encodeStore(5'(i - 55), 12'h100);
    end
    programWords[63] = encodeBranch(1'b0, 5'd0, 5'd0, 13'd0);
  endtask

  // sequential ISA model that runs one instruction at a time
  task automatic runModel();
    logic [xlen-1:0] regs [32];
    logic [xlen-1:0] ram [memWords];
    logic [xlen-1:0] word;
    logic [xlen-1:0] a;
    logic [xlen-1:0] b;
    logic [xlen-1:0] address;
    logic [xlen-1:0] immI;
    logic [xlen-1:0] immS;
    logic [xlen-1:0] immB;
    logic [4:0] rd;
    int pc;
    int steps;
    for (int i = 0; i < 32; i++) begin
      regs[i] = '0;
    end
    for (int i = 0; i < memWords; i++) begin
      ram[i] = '0;
    end
    expectedLed = 8'h00;
    expectedAddress.delete();
    expectedData.delete();
    pc = 0;
    steps = 0;
    while (programWords[pc] != encodeBranch(1'b0, 5'd0, 5'd0, 13'd0) && steps < 1000) begin
      word = programWords[pc];
      a = regs[word[19:15]];
      b = regs[word[24:20]];
      rd = word[11:7];
      immI = {{20{word[31]}}, word[31:20]};
      immS = {{20{word[31]}}, word[31:25], word[11:7]};
      immB = {{19{word[31]}}, word[31], word[7], word[30:25], word[11:8], 1'b0};
      pc = pc + 1;
      case (word[6:0])
        opReg: begin
          case ({word[30], word[14:12]})
            4'b0000: regs[rd] = a + b;
            4'b1000: regs[rd] = a - b;
            4'b0111: regs[rd] = a & b;
            4'b0110: regs[rd] = a | b;
            4'b0100: regs[rd] = a ^ b;
            default: regs[rd] = {31'd0, $signed(a) < $signed(b)};
          endcase
        end
        opImm: regs[rd] = a + immI;
        opLoad: begin
          address = a + immI;
          if (address < mmioBase) begin
            regs[rd] = ram[address[memIndexWidth+1:2]];
          end else if (address == ledAddress) begin
            regs[rd] = {24'd0, expectedLed};
          end else begin
            regs[rd] = '0;
          end
        end
        opStore: begin
          address = a + immS;
          if (address < mmioBase) begin
            ram[address[memIndexWidth+1:2]] = b;
          end else if (address == ledAddress) begin
            expectedLed = b[7:0];
          end else if (address == storePortAddress) begin
            expectedAddress.push_back(address);
            expectedData.push_back(b);
          end
        end
        opBranch: begin
          if ((a == b) != word[12]) begin
            pc = pc - 1 + int'($signed(immB)) / 4;
          end
        end
        default: ;
      endcase
      regs[0] = '0;
      steps++;
    end
    if (steps >= 1000) begin
      failRun("the model never reached the final self loop");
    end
  endtask

  // program goes in under reset, then eight more reset cycles
  task automatic loadAndReset();
    for (int i = 0; i < memWords; i++) begin
      @(posedge clk);
      reset <= 1'b1;
      storeReady <= 1'b0;
      progWrite <= 1'b1;
      progAddress <= memIndexWidth'(i);
      progData <= programWords[i];
    end
    @(posedge clk);
    progWrite <= 1'b0;
    repeat (8) @(posedge clk);
    @(negedge clk);
    checkValid(storeValid, 1'b0);
    checkLed(led, 8'h00);
    @(posedge clk);
    reset <= 1'b0;
  endtask

  task automatic runProgram(input int number);
    int cycles;
    buildProgram();
    runModel();
    transfers = 0;
    expectedTransfers = expectedAddress.size();
    loadAndReset();
    cycles = 0;
    while (transfers < expectedTransfers && cycles < 2000) begin
      @(posedge clk);
      storeReady <= randomBelow(10) < 7;
      cycles++;
    end
    if (transfers < expectedTransfers) begin
      failRun($sformatf("program %0d timed out with %0d of %0d store transfers", number,
                        transfers, expectedTransfers));
    end
    // extra transfers would show up here
    repeat (20) begin
      @(posedge clk);
      storeReady <= 1'b1;
    end
    @(negedge clk);
    checkLed(led, expectedLed);
  endtask

  // store port consumer that sees valid and ready just before the transfer edge
  always @(negedge clk) begin
    if (!reset && storeValid === 1'b1 && storeReady === 1'b1) begin
      if (expectedAddress.size() == 0) begin
        failRun($sformatf("store transfer beyond the %0d expected", expectedTransfers));
      end else begin
        checkStore(storeAddress, storeData, expectedAddress.pop_front(),
                   expectedData.pop_front());
        transfers++;
      end
    end
  end

  initial begin
    reset = 1'b1;
    progWrite = 1'b0;
    progAddress = '0;
    progData = '0;
    storeReady = 1'b0;
    for (int run = 0; run < 4; run++) begin
      runProgram(run);
    end
    if (u_cpu.storeChecks.violations == 0) begin
      $display("PASS: all tests");
      $finish;
    end else begin
      $display("FAIL: see errors above");
      $fatal(1, "store port assertions failed");
    end
  end

endmodule

/* tb.f */
logic/cpuPkg.sv
logic/pipeBarrier.sv
logic/instructionMemory.sv
logic/decoder.sv
logic/registerFile.sv
logic/alu.sv
logic/hazardUnit.sv
logic/memoryManagementUnit.sv
logic/cpu.sv
tb/cpu_checker.sv
tb/cpuTb.sv

/* Makefile */
TOP = cpuTb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f tb.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f tb.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) > sim.log 2>&1; cat sim.log
	grep -q "PASS: all tests" sim.log

clean:
	rm -rf obj_dir sim.log
